/* design/sd_dispatch_pkg.sv */
//**********************************************************
// shared types for the six-port sd card dispatcher
// port order in port_id_e is also the grant priority order
//**********************************************************

package sd_dispatch_pkg;

   //*******************************************************
   // ports and masks
   //*******************************************************
   localparam int NUM_PORTS = 6;                 // controllers on one card

   typedef enum logic [2:0] {
      PORT_RK = 3'd0,                            // highest priority
      PORT_DW = 3'd1,
      PORT_DM = 3'd2,
      PORT_DB = 3'd3,
      PORT_DX = 3'd4,
      PORT_MY = 3'd5                             // lowest priority
   } port_id_e;

   typedef logic [NUM_PORTS-1:0] port_mask_t;    // req, grant, led, bit per port

   //*******************************************************
   // spi lines
   //*******************************************************
   typedef struct packed {
      logic cs;                                  // chip select, low active
      logic mosi;                                // data toward the card
      logic sclk;                                // serial clock
   } spi_lines_t;

   typedef spi_lines_t [NUM_PORTS-1:0] port_spi_t;   // one line set per port

   // card deselected, bus parked
   localparam spi_lines_t SPI_IDLE = '{cs: 1'b1, mosi: 1'b1, sclk: 1'b0};

   //*******************************************************
   // card layout
   //*******************************************************
   localparam int BANK_W   = 4;                  // disk bank switch width
   localparam int BASE_W   = 22;                 // per-port base width
   localparam int OFFSET_W = 1 + BANK_W + BASE_W;   // top bit always zero

   typedef logic [BANK_W-1:0]   bank_t;
   typedef logic [BASE_W-1:0]   base_t;
   typedef logic [OFFSET_W-1:0] card_offset_t;

   typedef card_offset_t [NUM_PORTS-1:0] port_offsets_t;
   typedef base_t        [NUM_PORTS-1:0] port_bases_t;

   // listed from MY down to RK so index matches port_id_e
   localparam port_bases_t PORT_BASE = {
      22'h02e000,                                // MY
      22'h02c000,                                // DX
      22'h030000,                                // DB, fixed bank
      22'h330000,                                // DM
      22'h00c000,                                // DW
      22'h000000                                 // RK
   };

   //*******************************************************
   // arbiter state
   //*******************************************************
   typedef enum logic {
      ARB_IDLE = 1'b0,                           // card free
      ARB_BUSY = 1'b1                            // one port holds the card
   } arb_state_e;

endpackage

/* design/disk_bank_regs.sv */
//**********************************************************
// bank switch register and per-port card start offsets
// bank loads only while the card is idle, DB ignores the bank
//**********************************************************

module disk_bank_regs (
   input  logic                          sdclock,          // sd clock domain
   input  logic                          reset_i,          // sync, active high
   input  logic                          card_busy_i,      // a port holds the card
   input  sd_dispatch_pkg::bank_t        sw_diskbank_i,    // raw switch value
   output sd_dispatch_pkg::port_offsets_t start_offset_o   // per-port start offsets
);

   sd_dispatch_pkg::bank_t bank_q;                         // bank seen by the disks

   //*******************************************************
   // bank register
   //*******************************************************
   always_ff @(posedge sdclock) begin
      if (reset_i) begin
         bank_q <= '0;                                     // offsets equal bases
      end else if (!card_busy_i) begin
         bank_q <= sw_diskbank_i;                          // follow switch when idle
      end
   end

   //*******************************************************
   // offset build, zero bit then bank then base
   //*******************************************************
   for (genvar p = 0; p < sd_dispatch_pkg::NUM_PORTS; p++) begin : g_offset
      if (p == int'(sd_dispatch_pkg::PORT_DB)) begin : g_fixed
         // DB lives in a fixed area of the card
         assign start_offset_o[p] = {1'b0,
                                     {sd_dispatch_pkg::BANK_W{1'b0}},
                                     sd_dispatch_pkg::PORT_BASE[p]};
      end else begin : g_banked
         assign start_offset_o[p] = {1'b0,
                                     bank_q,                 // selected disk bank
                                     sd_dispatch_pkg::PORT_BASE[p]};
      end
   end

   //*******************************************************
   // checks
   //*******************************************************
   // no offset may move under a running transfer
   a_bank_hold : assert property (
      @(posedge sdclock) disable iff (reset_i)
      (!reset_i && card_busy_i) |=> $stable(bank_q)
   ) else $error("bank register changed while card busy");

endmodule

/* design/sd_card_arbiter.sv */
//**********************************************************
// sd card access arbiter, fixed priority RK first, MY last
// holder keeps the card until its synchronized request drops
// grant rises SYNC_STAGES edges after a request is sampled
//**********************************************************

module sd_card_arbiter #(
   parameter int SYNC_STAGES = 2                            // synchronizer depth, >= 1
) (
   input  logic                        sdclock,             // sd clock domain
   input  logic                        reset_i,             // sync, active high
   input  sd_dispatch_pkg::port_mask_t sd_req_i,            // raw request levels
   output sd_dispatch_pkg::port_mask_t sd_grant_o,          // one-hot or zero
   output logic                        card_busy_o,         // some port holds card
   output sd_dispatch_pkg::port_mask_t disk_led_o           // activity leds, low lit
);

   sd_dispatch_pkg::port_mask_t [SYNC_STAGES-1:0] sync_q;   // per-port shift chains
   sd_dispatch_pkg::port_mask_t                   req_sync; // last chain stage
   sd_dispatch_pkg::port_mask_t                   pick;     // top priority request
   sd_dispatch_pkg::port_mask_t                   grant_q;
   sd_dispatch_pkg::port_mask_t                   grant_d;
   sd_dispatch_pkg::arb_state_e                   state_q;
   sd_dispatch_pkg::arb_state_e                   state_d;

   //*******************************************************
   // request synchronizers
   //*******************************************************
   always_ff @(posedge sdclock) begin
      if (reset_i) begin
         sync_q <= '0;                                      // chains cleared
      end else begin
         sync_q[0] <= sd_req_i;                             // first stage
         for (int s = 1; s < SYNC_STAGES; s++) begin
            sync_q[s] <= sync_q[s-1];                       // shift along
         end
      end
   end

   assign req_sync = sync_q[SYNC_STAGES-1];

   //*******************************************************
   // fixed priority pick, lowest index wins
   //*******************************************************
   always_comb begin
      pick = '0;
      for (int i = sd_dispatch_pkg::NUM_PORTS - 1; i >= 0; i--) begin
         if (req_sync[i]) begin
            pick    = '0;                                   // drop lower one
            pick[i] = 1'b1;
         end
      end
   end

   //*******************************************************
   // idle/busy fsm
   //*******************************************************
   always_comb begin
      state_d = state_q;
      grant_d = grant_q;
      case (state_q)
         sd_dispatch_pkg::ARB_IDLE: begin
            if (req_sync != '0) begin
               state_d = sd_dispatch_pkg::ARB_BUSY;         // hand out the card
               grant_d = pick;
            end
         end
         sd_dispatch_pkg::ARB_BUSY: begin
            if ((grant_q & req_sync) == '0) begin
               state_d = sd_dispatch_pkg::ARB_IDLE;         // holder let go
               grant_d = '0;
            end
         end
         default: begin
            state_d = sd_dispatch_pkg::ARB_IDLE;            // recover
            grant_d = '0;
         end
      endcase
   end

   always_ff @(posedge sdclock) begin
      if (reset_i) begin
         state_q <= sd_dispatch_pkg::ARB_IDLE;
         grant_q <= '0;
      end else begin
         state_q <= state_d;
         grant_q <= grant_d;
      end
   end

   //*******************************************************
   // outputs
   //*******************************************************
   assign sd_grant_o  = grant_q;
   assign card_busy_o = (state_q == sd_dispatch_pkg::ARB_BUSY);
   assign disk_led_o  = ~sd_req_i;                          // raw request, inverted

   //*******************************************************
   // checks
   //*******************************************************
   a_grant_onehot : assert property (
      @(posedge sdclock) disable iff (reset_i)
      $onehot0(grant_q)
   ) else $error("more than one port granted");

   // grant and fsm state must agree every cycle
   a_grant_state : assert property (
      @(posedge sdclock) disable iff (reset_i)
      (grant_q != '0) == (state_q == sd_dispatch_pkg::ARB_BUSY)
   ) else $error("grant does not match arbiter state");

endmodule

/* design/sd_line_mux.sv */
//**********************************************************
// steers the granted port's spi lines onto the card
// purely combinational, idle levels when nobody holds grant
//**********************************************************

module sd_line_mux (
   input  logic                        sdclock,       // only samples the check
   input  sd_dispatch_pkg::port_mask_t sd_grant_i,    // one-hot or zero
   input  sd_dispatch_pkg::port_spi_t  port_spi_i,    // lines from each controller
   output sd_dispatch_pkg::spi_lines_t card_spi_o     // lines to the card
);

   //*******************************************************
   // line select
   //*******************************************************
   always_comb begin
      card_spi_o = sd_dispatch_pkg::SPI_IDLE;         // parked by default
      for (int i = 0; i < sd_dispatch_pkg::NUM_PORTS; i++) begin
         if (sd_grant_i[i]) begin
            card_spi_o = port_spi_i[i];               // holder drives the card
         end
      end
   end

   //*******************************************************
   // checks
   //*******************************************************
   // card must stay deselected with no holder
   a_idle_cs : assert property (
      @(posedge sdclock)
      (sd_grant_i == '0) |-> card_spi_o.cs
   ) else $error("card selected with no grant");

endmodule

/* design/sd_dispatch_top.sv */
//**********************************************************
// sd card dispatcher top, six disk controllers on one card
// requests and grants are plain levels, no handshake
// all logic on sdclock, reset_i synchronous
//**********************************************************

module sd_dispatch_top #(
   parameter int SYNC_STAGES = 2                             // request sync depth
) (
   input  logic                          sdclock,            // sd clock domain
   input  logic                          reset_i,            // sync, active high
   input  sd_dispatch_pkg::port_mask_t   sd_req_i,           // controller requests
   input  sd_dispatch_pkg::port_spi_t    port_spi_i,         // controller spi lines
   input  sd_dispatch_pkg::bank_t        sw_diskbank_i,      // disk bank switch
   output sd_dispatch_pkg::port_mask_t   sd_grant_o,         // card grant per port
   output sd_dispatch_pkg::spi_lines_t   card_spi_o,         // lines to the card
   output sd_dispatch_pkg::port_offsets_t start_offset_o,    // per-port card offsets
   output sd_dispatch_pkg::port_mask_t   disk_led_o          // activity leds
);

   logic card_busy;                                          // arbiter to bank regs

   //*******************************************************
   // arbiter
   //*******************************************************
   sd_card_arbiter #(
      .SYNC_STAGES (SYNC_STAGES)
   ) arb0 (
      .sdclock     (sdclock),
      .reset_i     (reset_i),
      .sd_req_i    (sd_req_i),
      .sd_grant_o  (sd_grant_o),                             // also steers the mux
      .card_busy_o (card_busy),
      .disk_led_o  (disk_led_o)
   );

   //*******************************************************
   // card line mux
   //*******************************************************
   sd_line_mux mux0 (
      .sdclock    (sdclock),
      .sd_grant_i (sd_grant_o),
      .port_spi_i (port_spi_i),
      .card_spi_o (card_spi_o)
   );

   //*******************************************************
   // bank register and offsets
   //*******************************************************
   disk_bank_regs bank0 (
      .sdclock        (sdclock),
      .reset_i        (reset_i),
      .card_busy_i    (card_busy),                           // freeze bank in transfer
      .sw_diskbank_i  (sw_diskbank_i),
      .start_offset_o (start_offset_o)
   );

endmodule

/* verification/tb_sd_checks.svh */
//**********************************************************
// typed compare tasks and error counters for tb_sd_dispatch
// included inside the testbench module body
//**********************************************************

`ifndef TB_SD_CHECKS_SVH
`define TB_SD_CHECKS_SVH

int mismatch_count = 0;                            // wrong values seen
int failure_count  = 0;                            // timeouts, bad trace data
int check_count    = 0;                            // compares done

task automatic check_mask(input string                       name,
                          input sd_dispatch_pkg::port_mask_t expected,
                          input sd_dispatch_pkg::port_mask_t actual);
   check_count++;
   if (actual !== expected) begin
      mismatch_count++;
      $display("MISMATCH time=%0t %s expected=%b actual=%b",
               $time, name, expected, actual);
   end
endtask

task automatic check_lines(input string                       name,
                           input sd_dispatch_pkg::spi_lines_t expected,
                           input sd_dispatch_pkg::spi_lines_t actual);
   check_count++;
   if (actual !== expected) begin
      mismatch_count++;                            // shown as cs mosi sclk
      $display("MISMATCH time=%0t %s expected=%b actual=%b",
               $time, name, expected, actual);
   end
endtask

task automatic check_offsets(input string                          name,
                             input sd_dispatch_pkg::port_offsets_t expected,
                             input sd_dispatch_pkg::port_offsets_t actual);
   sd_dispatch_pkg::port_id_e port;
   for (int p = 0; p < sd_dispatch_pkg::NUM_PORTS; p++) begin
      port = sd_dispatch_pkg::port_id_e'(p[2:0]);
      check_count++;
      if (actual[p] !== expected[p]) begin
         mismatch_count++;                         // one line per port
         $display("MISMATCH time=%0t %s[%s] expected=%h actual=%h",
                  $time, name, port.name(), expected[p], actual[p]);
      end
   end
endtask

task automatic report_failure(input string what);
   failure_count++;
   $display("ERROR time=%0t %s", $time, what);
endtask

task automatic print_summary();
   $display("errors: %0d mismatches, %0d other failures, %0d checks done",
            mismatch_count, failure_count, check_count);
endtask

`endif

/* verification/tb_sd_dispatch.sv */
//**********************************************************
// testbench for sd_dispatch_top, trace read from the project root
// trace steps end at a line whose hold field is zero
//**********************************************************

module tb_sd_dispatch;

   localparam int          CLK_PERIOD     = 20;
   localparam int          RESET_CYCLES   = 2;
   localparam int          SYNC_STAGES    = 2;     // must match dut0 below
   localparam int          TIMEOUT_MARGIN = 20;
   localparam int          MAX_STEPS      = 64;
   localparam int unsigned LCG_SEED       = 11;

   logic                           sdclock;
   logic                           reset;
   sd_dispatch_pkg::port_mask_t    sd_req;
   sd_dispatch_pkg::port_spi_t     port_spi;
   sd_dispatch_pkg::bank_t         bank_sw;
   sd_dispatch_pkg::port_mask_t    grant;
   sd_dispatch_pkg::spi_lines_t    card_spi;
   sd_dispatch_pkg::port_offsets_t start_offset;
   sd_dispatch_pkg::port_mask_t    disk_led;

   logic [7:0]  trace_mem [0:4*MAX_STEPS-1];      // req, bank, hold, grant per step
   int          num_steps;
   int          timeout_limit = 0;
   int          cycle_count   = 0;
   logic        checks_on;
   int unsigned lcg_state;

   sd_dispatch_pkg::port_mask_t [SYNC_STAGES-1:0] ref_sync;   // model sync chain
   sd_dispatch_pkg::port_mask_t                   ref_grant;  // model grant
   sd_dispatch_pkg::bank_t                        ref_bank;   // model bank register

   `include "tb_sd_checks.svh"

   sd_dispatch_top #(
      .SYNC_STAGES    (SYNC_STAGES)
   ) dut0 (
      .sdclock        (sdclock),
      .reset_i        (reset),
      .sd_req_i       (sd_req),
      .port_spi_i     (port_spi),
      .sw_diskbank_i  (bank_sw),
      .sd_grant_o     (grant),
      .card_spi_o     (card_spi),
      .start_offset_o (start_offset),
      .disk_led_o     (disk_led)
   );

   //*******************************************************
   // expected values from the dispatcher rules
   //*******************************************************
   function automatic int unsigned lcg_next(input int unsigned state);
      return state * 32'd1103515245 + 32'd12345;
   endfunction

   // first set bit wins, port order is priority order
   function automatic sd_dispatch_pkg::port_mask_t top_request(
      input sd_dispatch_pkg::port_mask_t req);
      sd_dispatch_pkg::port_mask_t winner;
      winner = '0;
      for (int i = 0; i < sd_dispatch_pkg::NUM_PORTS; i++) begin
         if (req[i] && winner == '0) begin
            winner[i] = 1'b1;
         end
      end
      return winner;
   endfunction

   function automatic sd_dispatch_pkg::spi_lines_t expected_lines(
      input sd_dispatch_pkg::port_mask_t gnt,
      input sd_dispatch_pkg::port_spi_t  spi);
      sd_dispatch_pkg::spi_lines_t lines;
      lines = sd_dispatch_pkg::SPI_IDLE;           // nobody on the card
      for (int i = 0; i < sd_dispatch_pkg::NUM_PORTS; i++) begin
         if (gnt[i]) begin
            lines = spi[i];
         end
      end
      return lines;
   endfunction

   function automatic sd_dispatch_pkg::port_offsets_t expected_offsets(
      input sd_dispatch_pkg::bank_t bank);
      sd_dispatch_pkg::port_offsets_t offs;
      sd_dispatch_pkg::bank_t         bank_part;
      for (int p = 0; p < sd_dispatch_pkg::NUM_PORTS; p++) begin
         if (p == int'(sd_dispatch_pkg::PORT_DB)) begin
            bank_part = '0;                        // DB bank is fixed
         end else begin
            bank_part = bank;
         end
         offs[p] = {1'b0, bank_part, sd_dispatch_pkg::PORT_BASE[p]};
      end
      return offs;
   endfunction

   // grant after SYNC_STAGES edges, held until holder drops
   always @(posedge sdclock) begin
      if (reset) begin
         ref_sync  <= '0;
         ref_grant <= '0;
         ref_bank  <= '0;
      end else begin
         ref_sync[0] <= sd_req;
         for (int s = 1; s < SYNC_STAGES; s++) begin
            ref_sync[s] <= ref_sync[s-1];
         end
         if (ref_grant == '0) begin
            ref_bank  <= bank_sw;                  // idle card follows switch
            ref_grant <= top_request(ref_sync[SYNC_STAGES-1]);
         end else if ((ref_grant & ref_sync[SYNC_STAGES-1]) == '0) begin
            ref_grant <= '0;                       // holder let go
         end
      end
   end

   //*******************************************************
   // clock, spi source, watchdog, per-cycle checks
   //*******************************************************
   initial begin
      sdclock = 1'b0;
      forever #(CLK_PERIOD/2) sdclock = ~sdclock;
   end

   initial begin : spi_source
      lcg_state = LCG_SEED;
      port_spi  = '0;
      forever begin
         @(posedge sdclock);
         lcg_state = lcg_next(lcg_state);
         port_spi <= sd_dispatch_pkg::port_spi_t'(lcg_state[30:13]);   // upper lcg bits
      end
   end

   always @(posedge sdclock) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= timeout_limit) begin
         report_failure("run did not finish within the cycle limit");
         print_summary();
         $display("=== FAIL ===");
         $finish;
      end
   end

   always @(negedge sdclock) begin
      if (checks_on) begin
         check_mask("sd_grant_o", ref_grant, grant);
         check_lines("card_spi_o", expected_lines(ref_grant, port_spi), card_spi);
         check_offsets("start_offset_o", expected_offsets(ref_bank), start_offset);
         check_mask("disk_led_o", ~sd_req, disk_led);
      end
   end

   //*******************************************************
   // main flow
   //*******************************************************
   initial begin : main_flow
      int                          hold_sum;
      int                          hold;
      sd_dispatch_pkg::port_mask_t exp_grant;

      sd_req    = '0;
      bank_sw   = '0;
      reset     = 1'b1;
      checks_on = 1'b0;

      $readmemh("verification/sd_dispatch_trace.txt", trace_mem);
      num_steps = 0;
      hold_sum  = 0;
      while (num_steps < MAX_STEPS && trace_mem[4*num_steps+2] != 8'h00) begin
         if (int'(trace_mem[4*num_steps+2]) < 3) begin
            report_failure($sformatf("trace step %0d holds fewer than 3 cycles", num_steps));
         end
         hold_sum += int'(trace_mem[4*num_steps+2]);
         num_steps++;
      end
      if (num_steps == 0) begin
         report_failure("trace file holds no steps");
      end
      timeout_limit = hold_sum + RESET_CYCLES + TIMEOUT_MARGIN;

      repeat (RESET_CYCLES) @(posedge sdclock);
      reset <= 1'b0;
      @(negedge sdclock);
      check_mask("sd_grant_o after reset", '0, grant);
      check_lines("card_spi_o after reset", sd_dispatch_pkg::SPI_IDLE, card_spi);
      check_offsets("start_offset_o after reset", expected_offsets('0), start_offset);
      checks_on <= 1'b1;                           // per-cycle checks from next cycle

      for (int s = 0; s < num_steps; s++) begin
         @(posedge sdclock);
         sd_req    <= trace_mem[4*s][5:0];
         bank_sw   <= trace_mem[4*s+1][3:0];
         hold      = int'(trace_mem[4*s+2]);
         exp_grant = trace_mem[4*s+3][5:0];
         repeat (hold) @(negedge sdclock);
         if (ref_grant !== exp_grant) begin
            report_failure($sformatf("trace step %0d expects grant %b, model has %b",
                                     s, exp_grant, ref_grant));
         end
         check_mask("sd_grant_o at end of hold", exp_grant, grant);
      end

      @(posedge sdclock);
      print_summary();
      if (mismatch_count == 0 && failure_count == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

/* verification/sd_dispatch_trace.txt */
// columns, all hex: request mask (bit0 RK .. bit5 MY), bank switch,
// hold cycles, expected grant at the end of the hold; hold 00 ends the trace
00 0 04 00
// lone request from each port, bank moves while idle
01 3 06 01
00 3 06 00
02 5 06 02
00 5 06 00
04 a 06 04
00 a 06 00
08 c 06 08
00 c 06 00
10 f 06 10
00 f 06 00
20 6 06 20
00 6 06 00
// bank changes under a held grant
01 2 06 01
01 9 06 01
01 4 06 01
00 4 06 00
// simultaneous requests from idle
3f 1 06 01
00 1 06 00
3e 1 06 02
00 1 06 00
3c 7 06 04
00 7 06 00
38 7 06 08
00 7 06 00
30 b 06 10
00 b 06 00
28 b 06 08
00 b 06 00
24 5 06 04
00 5 06 00
// grant and release timing with short holds
04 d 03 00
04 d 03 04
00 d 03 04
00 d 03 00
// holder keeps the card against higher priority
10 2 06 10
11 2 08 10
13 8 06 10
03 8 06 01
02 8 06 02
00 8 06 00
// hand-over with the one idle cycle between grants
20 e 06 20
24 e 06 20
04 e 04 00
04 e 03 04
05 3 06 04
01 3 06 01
00 3 06 00
// DB and DX waiting behind MY
20 9 06 20
38 9 06 20
18 6 06 08
10 6 06 10
00 6 06 00
00 0 06 00
00 0 00 00

/* project.f */
+incdir+verification
design/sd_dispatch_pkg.sv
design/disk_bank_regs.sv
design/sd_card_arbiter.sv
design/sd_line_mux.sv
design/sd_dispatch_top.sv
verification/tb_sd_dispatch.sv

/* run.sh */
#!/bin/sh
# build and run the sd dispatcher testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_sd_dispatch \
   -f project.f -o tb_sd_dispatch || { echo "build failed"; exit 1; }
out=$(./obj_dir/tb_sd_dispatch)
echo "$out"
echo "$out" | grep -qx "=== PASS ===" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
